// File: load_pkg.sv
`default_nettype none

package load_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // data word and result width
  localparam int unsigned XLEN       = 64;
  // virtual and physical address widths
  localparam int unsigned VLEN       = 32;
  localparam int unsigned PLEN       = 32;
  // cache index, also the page offset seen by the store unit
  localparam int unsigned IDX_W      = 12;
  localparam int unsigned TAG_W      = 20;
  // scoreboard id
  localparam int unsigned TRANS_ID_W = 3;
  // outstanding load buffer
  localparam int unsigned NR_LDBUF   = 4;
  localparam int unsigned LDBUF_ID_W = 2;
  // byte offset inside one data word
  localparam int unsigned OFFS_W     = 3;

  // ------------------------------
  // encodings
  // ------------------------------

  typedef enum logic [2:0] {
    OP_LB,
    OP_LBU,
    OP_LH,
    OP_LHU,
    OP_LW,
    OP_LWU,
    OP_LD
  } load_op_e;

  // request FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_GNT,
    ST_SEND_TAG,
    ST_WAIT_PAGE_OFFSET,
    ST_ABORT,
    ST_WAIT_TRANSLATION,
    ST_WAIT_FLUSH
  } ld_state_e;

endpackage

`default_nettype wire

// File: load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module load_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  // issue side
  input  logic                                 valid_i,
  input  logic [load_pkg::TRANS_ID_W-1:0]      trans_id_i,
  input  logic [load_pkg::VLEN-1:0]            vaddr_i,
  input  load_pkg::load_op_e                   op_i,
  output logic                                 pop_ld_o,
  // translation and store-unit address check
  output logic                                 translation_req_o,
  output logic [load_pkg::IDX_W-1:0]           page_offset_o,
  input  logic [load_pkg::PLEN-1:0]            paddr_i,
  input  logic                                 dtlb_hit_i,
  input  logic                                 page_offset_matches_i,
  // cache request
  output logic                                 data_req_o,
  input  logic                                 gnt_i,
  output logic [load_pkg::IDX_W-1:0]           addr_index_o,
  output logic [load_pkg::TAG_W-1:0]           addr_tag_o,
  output logic [1:0]                           data_size_o,
  output logic [load_pkg::LDBUF_ID_W-1:0]      data_id_o,
  output logic                                 tag_valid_o,
  output logic                                 kill_req_o,
  input  logic                                 rvalid_i,
  // load buffer write side
  input  logic [load_pkg::NR_LDBUF-1:0]        slot_valid_i,
  output logic [load_pkg::NR_LDBUF-1:0]        slot_we_o,
  output logic [load_pkg::TRANS_ID_W-1:0]      wr_trans_id_o,
  output logic [load_pkg::OFFS_W-1:0]          wr_offset_o,
  output load_pkg::load_op_e                   wr_op_o,
  output logic [load_pkg::LDBUF_ID_W-1:0]      last_id_o
);
  import load_pkg::*;

  ld_state_e             state_d, state_q;
  logic                  buf_full;
  logic                  accept_req;
  logic                  in_flight;
  logic [LDBUF_ID_W-1:0] free_idx;
  logic [LDBUF_ID_W-1:0] last_id_q;

  // ------------------------------
  // free slot selection
  // ------------------------------

  assign buf_full = &slot_valid_i;

  // lowest numbered invalid slot wins
  always_comb begin : free_slot_sel
    free_idx = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!slot_valid_i[i]) begin
        free_idx = LDBUF_ID_W'(i);
      end
    end
  end

  // ------------------------------
  // request fields
  // ------------------------------

  // index goes out with the request, tag one cycle later
  assign page_offset_o = vaddr_i[IDX_W-1:0];
  assign addr_index_o  = vaddr_i[IDX_W-1:0];
  assign addr_tag_o    = paddr_i[IDX_W +: TAG_W];
  // request id is the slot that will hold the load
  assign data_id_o     = free_idx;

  always_comb begin : size_dec
    case (op_i)
      OP_LB, OP_LBU: data_size_o = 2'd0;
      OP_LH, OP_LHU: data_size_o = 2'd1;
      OP_LW, OP_LWU: data_size_o = 2'd2;
      default:       data_size_o = 2'd3;
    endcase
  end

  // metadata captured by the selected slot
  assign wr_trans_id_o = trans_id_i;
  assign wr_offset_o   = vaddr_i[OFFS_W-1:0];
  assign wr_op_o       = op_i;

  // a load granted in the flush cycle gets killed, so do not track it
  always_comb begin : slot_write
    slot_we_o           = '0;
    slot_we_o[free_idx] = pop_ld_o && !flush_i;
  end

  // ------------------------------
  // request FSM
  // ------------------------------

  always_comb begin : load_fsm
    state_d           = state_q;
    translation_req_o = 1'b0;
    data_req_o        = 1'b0;
    tag_valid_o       = 1'b0;
    kill_req_o        = 1'b0;
    pop_ld_o          = 1'b0;
    accept_req        = valid_i && !buf_full;

    case (state_q)
      // SEND_TAG drives the tag and can take the next load in the same cycle
      ST_IDLE, ST_SEND_TAG: begin
        tag_valid_o = (state_q == ST_SEND_TAG);
        state_d     = ST_IDLE;
        if (accept_req) begin
          // translate early, the address check runs in parallel
          translation_req_o = 1'b1;
          if (page_offset_matches_i) begin
            state_d = ST_WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            if (!gnt_i) begin
              state_d = ST_WAIT_GNT;
            end else if (!dtlb_hit_i) begin
              state_d = ST_ABORT;
            end else begin
              state_d  = ST_SEND_TAG;
              pop_ld_o = 1'b1;
            end
          end
        end
      end

      // older store to the same page offset still pending
      ST_WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = ST_WAIT_GNT;
        end
      end

      ST_WAIT_GNT: begin
        // hold both requests until the cache grants
        translation_req_o = 1'b1;
        data_req_o        = 1'b1;
        if (gnt_i) begin
          if (!dtlb_hit_i) begin
            state_d = ST_ABORT;
          end else begin
            state_d  = ST_SEND_TAG;
            pop_ld_o = 1'b1;
          end
        end
      end

      // tlb miss at grant, release the cache for the page walker
      ST_ABORT: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = ST_WAIT_TRANSLATION;
      end

      ST_WAIT_TRANSLATION: begin
        translation_req_o = 1'b1;
        if (dtlb_hit_i) begin
          state_d = ST_WAIT_GNT;
        end
      end

      // kill whatever was granted in the flush cycle
      ST_WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = ST_IDLE;
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase

    // extra kill cycle only if a request or response may still be in flight
    in_flight = (state_q != ST_IDLE) || data_req_o || (|slot_valid_i) || rvalid_i;
    if (flush_i && in_flight) begin
      state_d = ST_WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      last_id_q <= '0;
    end else begin
      state_q <= state_d;
      // id of the last granted request, target of a later kill
      if (data_req_o && gnt_i) begin
        last_id_q <= free_idx;
      end
    end
  end

  assign last_id_o = last_id_q;

endmodule

`default_nettype wire

// File: ldbuf_slot.sv
`timescale 1ns/1ps
`default_nettype none

module ldbuf_slot (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  logic                            we_i,
  input  logic                            release_i,
  input  logic [load_pkg::TRANS_ID_W-1:0] trans_id_i,
  input  logic [load_pkg::OFFS_W-1:0]     offset_i,
  input  load_pkg::load_op_e              op_i,
  output logic                            valid_o,
  output logic                            flushed_o,
  output logic [load_pkg::TRANS_ID_W-1:0] trans_id_o,
  output logic [load_pkg::OFFS_W-1:0]     offset_o,
  output load_pkg::load_op_e              op_o
);
  import load_pkg::*;

  logic                  valid_q;
  logic                  flushed_q;
  logic [TRANS_ID_W-1:0] trans_id_q;
  logic [OFFS_W-1:0]     offset_q;
  load_op_e              op_q;

  // occupancy flags, a new load overrides a release of the old one
  always_ff @(posedge clk_i or negedge rst_ni) begin : flag_regs
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      flushed_q <= 1'b0;
    end else if (we_i) begin
      valid_q   <= 1'b1;
      flushed_q <= 1'b0;
    end else begin
      if (release_i) begin
        valid_q <= 1'b0;
      end
      // response still expected but must not retire
      if (flush_i && valid_q) begin
        flushed_q <= 1'b1;
      end
    end
  end

  // load metadata
  always_ff @(posedge clk_i) begin : meta_regs
    if (we_i) begin
      trans_id_q <= trans_id_i;
      offset_q   <= offset_i;
      op_q       <= op_i;
    end
  end

  assign valid_o    = valid_q;
  assign flushed_o  = flushed_q;
  assign trans_id_o = trans_id_q;
  assign offset_o   = offset_q;
  assign op_o       = op_q;

endmodule

`default_nettype wire

// File: load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  logic                                                 rvalid_i,
  input  logic [load_pkg::LDBUF_ID_W-1:0]                      rid_i,
  input  logic [load_pkg::XLEN-1:0]                            rdata_i,
  input  logic                                                 kill_req_i,
  input  logic [load_pkg::LDBUF_ID_W-1:0]                      last_id_i,
  input  logic [load_pkg::NR_LDBUF-1:0]                        slot_valid_i,
  input  logic [load_pkg::NR_LDBUF-1:0]                        slot_flushed_i,
  input  logic [load_pkg::NR_LDBUF-1:0][load_pkg::TRANS_ID_W-1:0] slot_trans_id_i,
  input  logic [load_pkg::NR_LDBUF-1:0][load_pkg::OFFS_W-1:0]  slot_offset_i,
  input  load_pkg::load_op_e [load_pkg::NR_LDBUF-1:0]          slot_op_i,
  output logic [load_pkg::NR_LDBUF-1:0]                        slot_release_o,
  output logic                                                 valid_o,
  output logic [load_pkg::TRANS_ID_W-1:0]                      trans_id_o,
  output logic [load_pkg::XLEN-1:0]                            result_o
);
  import load_pkg::*;

  load_op_e            sel_op;
  logic [OFFS_W-1:0]   sel_offset;
  logic [OFFS_W-1:0]   sign_offset;
  logic [XLEN/8-1:0]   sign_bits;
  logic                is_signed;
  logic                sign_bit;
  logic [XLEN-1:0]     shifted_data;

  // ------------------------------
  // retire
  // ------------------------------

  assign sel_op     = slot_op_i[rid_i];
  assign sel_offset = slot_offset_i[rid_i];
  assign trans_id_o = slot_trans_id_i[rid_i];

  // every response frees its slot
  always_comb begin : release_sel
    slot_release_o        = '0;
    slot_release_o[rid_i] = rvalid_i;
  end

  // drop flushed loads and the one being killed right now
  assign valid_o = rvalid_i && slot_valid_i[rid_i] && !slot_flushed_i[rid_i]
                   && !(kill_req_i && (rid_i == last_id_i));

  // ------------------------------
  // format
  // ------------------------------

  assign shifted_data = rdata_i >> {sel_offset, 3'b000};

  // top bit of every byte of the raw word
  for (genvar i = 0; i < XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[8*i+7];
  end

  // sign byte picked from the raw word, next to the shifter
  always_comb begin : sign_sel
    case (sel_op)
      OP_LW, OP_LWU: sign_offset = sel_offset + OFFS_W'(3);
      OP_LH, OP_LHU: sign_offset = sel_offset + OFFS_W'(1);
      default:       sign_offset = sel_offset;
    endcase
  end

  assign is_signed = sel_op inside {OP_LB, OP_LH, OP_LW};
  // unsigned loads pull the fill to zero
  assign sign_bit  = is_signed & sign_bits[sign_offset];

  always_comb begin : result_mux
    case (sel_op)
      OP_LW, OP_LWU: result_o = {{(XLEN - 32){sign_bit}}, shifted_data[31:0]};
      OP_LH, OP_LHU: result_o = {{(XLEN - 16){sign_bit}}, shifted_data[15:0]};
      OP_LB, OP_LBU: result_o = {{(XLEN - 8){sign_bit}}, shifted_data[7:0]};
      default:       result_o = shifted_data;
    endcase
  end

endmodule

`default_nettype wire

// File: load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  // issue side
  input  logic                            valid_i,
  input  logic [load_pkg::TRANS_ID_W-1:0] trans_id_i,
  input  logic [load_pkg::VLEN-1:0]       vaddr_i,
  input  load_pkg::load_op_e              op_i,
  output logic                            pop_ld_o,
  // translation
  output logic                            translation_req_o,
  output logic [load_pkg::IDX_W-1:0]      page_offset_o,
  input  logic [load_pkg::PLEN-1:0]       paddr_i,
  input  logic                            dtlb_hit_i,
  input  logic                            page_offset_matches_i,
  // cache port
  output logic                            data_req_o,
  input  logic                            gnt_i,
  output logic [load_pkg::IDX_W-1:0]      addr_index_o,
  output logic [load_pkg::TAG_W-1:0]      addr_tag_o,
  output logic [1:0]                      data_size_o,
  output logic [load_pkg::LDBUF_ID_W-1:0] data_id_o,
  output logic                            tag_valid_o,
  output logic                            kill_req_o,
  input  logic                            rvalid_i,
  input  logic [load_pkg::LDBUF_ID_W-1:0] rid_i,
  input  logic [load_pkg::XLEN-1:0]       rdata_i,
  // writeback
  output logic                            valid_o,
  output logic [load_pkg::TRANS_ID_W-1:0] trans_id_o,
  output logic [load_pkg::XLEN-1:0]       result_o
);
  import load_pkg::*;

  // slot write side
  logic [NR_LDBUF-1:0]                 slot_we;
  logic [TRANS_ID_W-1:0]               wr_trans_id;
  logic [OFFS_W-1:0]                   wr_offset;
  load_op_e                            wr_op;
  logic [LDBUF_ID_W-1:0]               last_id;
  // slot state
  logic [NR_LDBUF-1:0]                 slot_valid;
  logic [NR_LDBUF-1:0]                 slot_flushed;
  logic [NR_LDBUF-1:0]                 slot_release;
  logic [NR_LDBUF-1:0][TRANS_ID_W-1:0] slot_trans_id;
  logic [NR_LDBUF-1:0][OFFS_W-1:0]     slot_offset;
  load_op_e [NR_LDBUF-1:0]             slot_op;

  load_ctrl u_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .trans_id_i            (trans_id_i),
    .vaddr_i               (vaddr_i),
    .op_i                  (op_i),
    .pop_ld_o              (pop_ld_o),
    .translation_req_o     (translation_req_o),
    .page_offset_o         (page_offset_o),
    .paddr_i               (paddr_i),
    .dtlb_hit_i            (dtlb_hit_i),
    .page_offset_matches_i (page_offset_matches_i),
    .data_req_o            (data_req_o),
    .gnt_i                 (gnt_i),
    .addr_index_o          (addr_index_o),
    .addr_tag_o            (addr_tag_o),
    .data_size_o           (data_size_o),
    .data_id_o             (data_id_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .rvalid_i              (rvalid_i),
    .slot_valid_i          (slot_valid),
    .slot_we_o             (slot_we),
    .wr_trans_id_o         (wr_trans_id),
    .wr_offset_o           (wr_offset),
    .wr_op_o               (wr_op),
    .last_id_o             (last_id)
  );

  // outstanding load buffer
  for (genvar g = 0; g < NR_LDBUF; g++) begin : gen_ldbuf
    ldbuf_slot u_slot (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .we_i       (slot_we[g]),
      .release_i  (slot_release[g]),
      .trans_id_i (wr_trans_id),
      .offset_i   (wr_offset),
      .op_i       (wr_op),
      .valid_o    (slot_valid[g]),
      .flushed_o  (slot_flushed[g]),
      .trans_id_o (slot_trans_id[g]),
      .offset_o   (slot_offset[g]),
      .op_o       (slot_op[g])
    );
  end

  load_align u_align (
    .rvalid_i        (rvalid_i),
    .rid_i           (rid_i),
    .rdata_i         (rdata_i),
    .kill_req_i      (kill_req_o),
    .last_id_i       (last_id),
    .slot_valid_i    (slot_valid),
    .slot_flushed_i  (slot_flushed),
    .slot_trans_id_i (slot_trans_id),
    .slot_offset_i   (slot_offset),
    .slot_op_i       (slot_op),
    .slot_release_o  (slot_release),
    .valid_o         (valid_o),
    .trans_id_o      (trans_id_o),
    .result_o        (result_o)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 20 ns period
  initial begin : clk_toggle
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // reset held low for 4 rising edges
  initial begin : rst_seq
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: load_unit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit_chk (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          data_req_i,
  input  logic                          gnt_i,
  input  logic                          pop_ld_i,
  input  logic                          tag_valid_i,
  input  logic [load_pkg::NR_LDBUF-1:0] slot_valid_i,
  input  load_pkg::ld_state_e           state_i
);
  import load_pkg::*;

  // full buffer blocks new cache requests
  a_no_req_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (&slot_valid_i) |-> !data_req_i
  ) else $error("data_req_o high while every load buffer slot is valid");

  // tag follows a grant, or comes with a kill
  a_tag_after_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tag_valid_i |-> ($past(data_req_i && gnt_i) || (state_i inside {ST_ABORT, ST_WAIT_FLUSH}))
  ) else $error("tag_valid_o without a grant in the previous cycle");

  a_pop_with_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_ld_i |-> gnt_i
  ) else $error("pop_ld_o high without gnt_i");

endmodule

`default_nettype wire

// File: load_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit_tb;
  import load_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  logic                  valid_in;
  logic [TRANS_ID_W-1:0] trans_id_in;
  logic [VLEN-1:0]       vaddr;
  load_op_e              op_in;
  logic                  pop_ld_o;
  logic                  translation_req_o;
  logic [IDX_W-1:0]      page_offset_o;
  logic [PLEN-1:0]       paddr;
  logic                  dtlb_hit;
  logic                  page_match;
  logic                  data_req_o;
  logic                  gnt;
  logic [IDX_W-1:0]      addr_index_o;
  logic [TAG_W-1:0]      addr_tag_o;
  logic [1:0]            data_size_o;
  logic [LDBUF_ID_W-1:0] data_id_o;
  logic                  tag_valid_o;
  logic                  kill_req_o;
  logic                  rvalid;
  logic [LDBUF_ID_W-1:0] rid;
  logic [XLEN-1:0]       rdata;
  logic                  valid_o;
  logic [TRANS_ID_W-1:0] trans_id_o;
  logic [XLEN-1:0]       result_o;

  // memory model and per-slot record of what was issued
  logic [XLEN-1:0]       mem_word [NR_LDBUF];
  logic [TRANS_ID_W-1:0] slot_tid [NR_LDBUF];
  load_op_e              slot_op_q [NR_LDBUF];
  int                    slot_offs [NR_LDBUF];

  // load currently being issued
  logic [TRANS_ID_W-1:0] cur_tid;
  load_op_e              cur_op;
  int                    cur_offs;
  logic [VLEN-1:0]       cur_vaddr;
  logic [PLEN-1:0]       cur_paddr;

  int wait_limit = 50;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  load_unit load_unit_i (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .flush_i               (flush),
    .valid_i               (valid_in),
    .trans_id_i            (trans_id_in),
    .vaddr_i               (vaddr),
    .op_i                  (op_in),
    .pop_ld_o              (pop_ld_o),
    .translation_req_o     (translation_req_o),
    .page_offset_o         (page_offset_o),
    .paddr_i               (paddr),
    .dtlb_hit_i            (dtlb_hit),
    .page_offset_matches_i (page_match),
    .data_req_o            (data_req_o),
    .gnt_i                 (gnt),
    .addr_index_o          (addr_index_o),
    .addr_tag_o            (addr_tag_o),
    .data_size_o           (data_size_o),
    .data_id_o             (data_id_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .rvalid_i              (rvalid),
    .rid_i                 (rid),
    .rdata_i               (rdata),
    .valid_o               (valid_o),
    .trans_id_o            (trans_id_o),
    .result_o              (result_o)
  );

  // protocol checks on the cache port
  bind load_unit load_unit_chk u_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req_o),
    .gnt_i        (gnt_i),
    .pop_ld_i     (pop_ld_o),
    .tag_valid_i  (tag_valid_o),
    .slot_valid_i (slot_valid),
    .state_i      (u_ctrl.state_q)
  );

  // ------------------------------
  // reporting
  // ------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  // shift down to the addressed byte, then extend at the access width
  function automatic logic [63:0] expect_result(input logic [63:0] word, input load_op_e lop,
                                                input int offs);
    logic [63:0] s;
    s = word >> (8 * offs);
    case (lop)
      OP_LB:   expect_result = {{56{s[7]}}, s[7:0]};
      OP_LBU:  expect_result = {56'd0, s[7:0]};
      OP_LH:   expect_result = {{48{s[15]}}, s[15:0]};
      OP_LHU:  expect_result = {48'd0, s[15:0]};
      OP_LW:   expect_result = {{32{s[31]}}, s[31:0]};
      OP_LWU:  expect_result = {32'd0, s[31:0]};
      default: expect_result = s;
    endcase
  endfunction

  // size code on the cache port is log2 of the access bytes
  function automatic logic [1:0] access_size(input load_op_e lop);
    int nbytes;
    case (lop)
      OP_LB, OP_LBU: nbytes = 1;
      OP_LH, OP_LHU: nbytes = 2;
      OP_LW, OP_LWU: nbytes = 4;
      default:       nbytes = 8;
    endcase
    access_size = 2'($clog2(nbytes));
  endfunction

  // naturally aligned offset for the access width
  function automatic int pick_offset(input load_op_e lop);
    case (lop)
      OP_LB, OP_LBU: pick_offset = int'($urandom % 8);
      OP_LH, OP_LHU: pick_offset = int'($urandom % 4) * 2;
      OP_LW, OP_LWU: pick_offset = int'($urandom % 2) * 4;
      default:       pick_offset = 0;
    endcase
  endfunction

  function automatic load_op_e rand_op();
    rand_op = load_op_e'(3'($urandom % 7));
  endfunction

  // ------------------------------
  // drivers
  // ------------------------------

  task automatic start_load(input logic [TRANS_ID_W-1:0] tid, input load_op_e lop, input int offs,
                            input logic gnt_v, input logic hit_v, input logic match_v);
    logic [VLEN-1:0] va;
    va        = $urandom();
    va[2:0]   = 3'(offs);
    cur_vaddr = va;
    cur_paddr = $urandom();
    cur_tid   = tid;
    cur_op    = lop;
    cur_offs  = offs;
    @(posedge clk);
    valid_in    <= 1'b1;
    trans_id_in <= tid;
    op_in       <= lop;
    vaddr       <= va;
    paddr       <= cur_paddr;
    gnt         <= gnt_v;
    dtlb_hit    <= hit_v;
    page_match  <= match_v;
  endtask

  // wait for acceptance, record the slot and check the tag cycle
  task automatic wait_accept(output logic [LDBUF_ID_W-1:0] slot, output int waited);
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (cnt > wait_limit) begin
        abort_run("timeout: load never accepted, pop_ld_o stayed low");
      end
    end while (!pop_ld_o);
    check_eq("data_req_o", 64'(data_req_o), 64'd1);
    // request fields of the granted cycle
    check_eq("addr_index_o", 64'(addr_index_o), 64'(cur_vaddr[11:0]));
    check_eq("page_offset_o", 64'(page_offset_o), 64'(cur_vaddr[11:0]));
    check_eq("data_size_o", 64'(data_size_o), 64'(access_size(cur_op)));
    slot            = data_id_o;
    waited          = cnt;
    slot_tid[slot]  = cur_tid;
    slot_op_q[slot] = cur_op;
    slot_offs[slot] = cur_offs;
    @(posedge clk);
    valid_in <= 1'b0;
    gnt      <= 1'b0;
    @(negedge clk);
    check_eq("tag_valid_o", 64'(tag_valid_o), 64'd1);
    check_eq("kill_req_o", 64'(kill_req_o), 64'd0);
    check_eq("addr_tag_o", 64'(addr_tag_o), 64'(cur_paddr[31:12]));
  endtask

  task automatic issue_load(input logic [TRANS_ID_W-1:0] tid, input load_op_e lop, input int offs,
                            output logic [LDBUF_ID_W-1:0] slot);
    int waited;
    start_load(tid, lop, offs, 1'b1, 1'b1, 1'b0);
    wait_accept(slot, waited);
  endtask

  // memory model, fresh word per response
  task automatic respond(input logic [LDBUF_ID_W-1:0] slot, input logic expect_valid);
    mem_word[slot] = {$urandom(), $urandom()};
    @(posedge clk);
    rvalid <= 1'b1;
    rid    <= slot;
    rdata  <= mem_word[slot];
    @(negedge clk);
    check_eq("valid_o", 64'(valid_o), 64'(expect_valid));
    if (expect_valid) begin
      check_eq("trans_id_o", 64'(trans_id_o), 64'(slot_tid[slot]));
      check_eq("result_o", result_o,
               expect_result(mem_word[slot], slot_op_q[slot], slot_offs[slot]));
    end
    @(posedge clk);
    rvalid <= 1'b0;
  endtask

  // ------------------------------
  // tests
  // ------------------------------

  task automatic format_loads();
    load_op_e              lop;
    logic [LDBUF_ID_W-1:0] slot;
    for (int i = 0; i < 7; i++) begin
      lop = load_op_e'(3'(i));
      repeat (3) begin
        issue_load(TRANS_ID_W'($urandom), lop, pick_offset(lop), slot);
        respond(slot, 1'b1);
      end
    end
  endtask

  task automatic outstanding_loads();
    logic [LDBUF_ID_W-1:0] slot;
    logic [LDBUF_ID_W-1:0] order [NR_LDBUF];
    logic [LDBUF_ID_W-1:0] tmp;
    load_op_e              lop;
    int                    j;
    int                    waited;
    for (int i = 0; i < NR_LDBUF; i++) begin
      lop = rand_op();
      issue_load(TRANS_ID_W'(i), lop, pick_offset(lop), slot);
      check_eq("data_id_o", 64'(slot), 64'(i));
      order[i] = LDBUF_ID_W'(i);
    end
    // shuffled response order
    for (int i = NR_LDBUF - 1; i > 0; i--) begin
      j        = int'($urandom % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    // fifth load has to wait for a free slot
    lop = rand_op();
    start_load(TRANS_ID_W'(5), lop, pick_offset(lop), 1'b1, 1'b1, 1'b0);
    repeat (3) begin
      @(negedge clk);
      check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
      check_eq("data_req_o", 64'(data_req_o), 64'd0);
    end
    respond(order[0], 1'b1);
    wait_accept(slot, waited);
    check_eq("data_id_o", 64'(slot), 64'(order[0]));
    for (int i = 1; i < NR_LDBUF; i++) begin
      respond(order[i], 1'b1);
    end
    respond(slot, 1'b1);
  endtask

  task automatic grant_delay();
    logic [LDBUF_ID_W-1:0] slot;
    load_op_e              lop;
    int                    d;
    int                    waited;
    lop = rand_op();
    d   = 1 + int'($urandom % 5);
    start_load(TRANS_ID_W'($urandom), lop, pick_offset(lop), 1'b0, 1'b1, 1'b0);
    for (int k = 0; k < d; k++) begin
      @(negedge clk);
      check_eq("data_req_o", 64'(data_req_o), 64'd1);
      check_eq("translation_req_o", 64'(translation_req_o), 64'd1);
      check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
    end
    @(posedge clk);
    gnt <= 1'b1;
    wait_accept(slot, waited);
    // pop exactly in the grant cycle
    check_eq("pop_ld_o delay", 64'(waited), 64'd1);
    respond(slot, 1'b1);
  endtask

  task automatic page_offset_stall();
    logic [LDBUF_ID_W-1:0] slot;
    load_op_e              lop;
    int                    waited;
    lop = rand_op();
    start_load(TRANS_ID_W'($urandom), lop, pick_offset(lop), 1'b1, 1'b1, 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_eq("data_req_o", 64'(data_req_o), 64'd0);
      check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
    end
    @(posedge clk);
    page_match <= 1'b0;
    wait_accept(slot, waited);
    respond(slot, 1'b1);
  endtask

  task automatic tlb_miss_retry();
    logic [LDBUF_ID_W-1:0] slot;
    load_op_e              lop;
    int                    waited;
    lop = rand_op();
    start_load(TRANS_ID_W'($urandom), lop, pick_offset(lop), 1'b1, 1'b0, 1'b0);
    @(negedge clk);
    check_eq("data_req_o", 64'(data_req_o), 64'd1);
    check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
    @(posedge clk);
    gnt <= 1'b0;
    // abort cycle
    @(negedge clk);
    check_eq("kill_req_o", 64'(kill_req_o), 64'd1);
    check_eq("tag_valid_o", 64'(tag_valid_o), 64'd1);
    repeat (2) begin
      @(negedge clk);
      check_eq("translation_req_o", 64'(translation_req_o), 64'd1);
      check_eq("data_req_o", 64'(data_req_o), 64'd0);
    end
    @(posedge clk);
    dtlb_hit <= 1'b1;
    gnt      <= 1'b1;
    wait_accept(slot, waited);
    respond(slot, 1'b1);
  endtask

  task automatic flush_discard();
    logic [LDBUF_ID_W-1:0] s0;
    logic [LDBUF_ID_W-1:0] s1;
    logic [LDBUF_ID_W-1:0] s2;
    load_op_e              lop;
    lop = rand_op();
    issue_load(TRANS_ID_W'(1), lop, pick_offset(lop), s0);
    lop = rand_op();
    issue_load(TRANS_ID_W'(2), lop, pick_offset(lop), s1);
    @(posedge clk);
    flush <= 1'b1;
    @(negedge clk);
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check_eq("kill_req_o", 64'(kill_req_o), 64'd1);
    check_eq("tag_valid_o", 64'(tag_valid_o), 64'd1);
    // new load lands next to the flushed ones
    lop = rand_op();
    issue_load(TRANS_ID_W'(3), lop, pick_offset(lop), s2);
    respond(s1, 1'b0);
    respond(s0, 1'b0);
    respond(s2, 1'b1);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin : main
    int cnt;
    void'($urandom(32'h7b37));
    flush       = 1'b0;
    valid_in    = 1'b0;
    trans_id_in = '0;
    vaddr       = '0;
    op_in       = OP_LB;
    paddr       = '0;
    dtlb_hit    = 1'b0;
    page_match  = 1'b0;
    gnt         = 1'b0;
    rvalid      = 1'b0;
    rid         = '0;
    rdata       = '0;
    cnt         = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > wait_limit) begin
        abort_run("timeout: reset never released");
      end
    end while (!rst_n);
    format_loads();
    outstanding_loads();
    grant_delay();
    page_offset_stall();
    tlb_miss_retry();
    flush_discard();
    repeat (2) @(posedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: load_unit.f
load_pkg.sv
load_ctrl.sv
ldbuf_slot.sv
load_align.sv
load_unit.sv
tb_clk_gen.sv
load_unit_chk.sv
load_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= load_unit_tb
FILELIST  ?= load_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(EXE) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
